// File: bench/dma_assert.sv
`default_nettype none
`timescale 1ns/100ps

module dma_assert (
  input logic                   clk,
  input logic                   rst,
  input logic [1:0]             i_take,
  input logic [1:0]             i_valid,
  input logic [1:0]             i_src_strobe,
  input logic [1:0]             i_src_activate,
  input logic [1:0]             i_snk_strobe,
  input dma_cfg_pkg::pp_t       i_snk0_activate,
  input dma_cfg_pkg::pp_t       i_snk1_activate
);

  // Source link handshake
  a_take_valid: assert property (@(posedge clk) disable iff (rst)
    (i_take & ~i_valid) == 2'b00)
    else $error("source take without valid");

  a_src_strobe: assert property (@(posedge clk) disable iff (rst)
    (i_src_strobe & ~i_src_activate) == 2'b00)
    else $error("source strobe while inactive");

  a_snk0_strobe: assert property (@(posedge clk) disable iff (rst)
    i_snk_strobe[0] |-> (i_snk0_activate != 2'b00))
    else $error("sink 0 strobe while inactive");

  a_snk1_strobe: assert property (@(posedge clk) disable iff (rst)
    i_snk_strobe[1] |-> (i_snk1_activate != 2'b00))
    else $error("sink 1 strobe while inactive");

  // Ping-pong buffers are exclusive
  a_one_buf: assert property (@(posedge clk) disable iff (rst)
    (i_snk0_activate != 2'b11) && (i_snk1_activate != 2'b11))
    else $error("two sink buffers active");

endmodule

bind dma_top dma_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .i_take          ({src_if[1].take, src_if[0].take}),
  .i_valid         ({src_if[1].valid, src_if[0].valid}),
  .i_src_strobe    ({o_src1_strobe, o_src0_strobe}),
  .i_src_activate  ({o_src1_activate, o_src0_activate}),
  .i_snk_strobe    ({o_snk1_strobe, o_snk0_strobe}),
  .i_snk0_activate (o_snk0_activate),
  .i_snk1_activate (o_snk1_activate)
);

`default_nettype wire

// File: bench/dma_tb.sv
`default_nettype none
`timescale 1ns/100ps

module dma_tb;

  // Cycle budget per test in run order
  localparam int WATCHDOG_CYCLES = 100 + 1100 + 1400 + 4100 + 2100 + 1100;

  logic                      clk;
  logic                      rst;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [7:0]                paddr;
  dma_cfg_pkg::word_t        pwdata;
  dma_cfg_pkg::word_t        prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      src0_ready;
  logic                      src1_ready;
  dma_cfg_pkg::word_t        src0_data;
  dma_cfg_pkg::word_t        src1_data;
  dma_cfg_pkg::count_t       src_size [2];
  logic                      src0_strobe;
  logic                      src1_strobe;
  logic                      src0_act;
  logic                      src1_act;
  dma_cfg_pkg::pp_t          snk0_ready;
  dma_cfg_pkg::pp_t          snk1_ready;
  dma_cfg_pkg::count_t       snk_size [2];
  logic                      snk0_strobe;
  logic                      snk1_strobe;
  dma_cfg_pkg::pp_t          snk0_act;
  dma_cfg_pkg::pp_t          snk1_act;
  dma_cfg_pkg::word_t        snk0_data;
  dma_cfg_pkg::word_t        snk1_data;
  logic [1:0]                busy;
  logic [1:0]                finished;

  integer                    seed = 22;
  logic                      gaps;
  dma_cfg_pkg::word_t        src_base [2];
  int                        src_idx [2];
  int                        src_cnt [2];
  dma_cfg_pkg::word_t        snk0_q [$];
  dma_cfg_pkg::word_t        snk1_q [$];

  dma_top uut (
    .clk (clk), .rst (rst),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata),
    .o_pready (pready), .o_pslverr (pslverr),
    .i_src0_ready (src0_ready), .i_src0_data (src0_data), .i_src0_size (src_size[0]),
    .o_src0_strobe (src0_strobe), .o_src0_activate (src0_act),
    .i_src1_ready (src1_ready), .i_src1_data (src1_data), .i_src1_size (src_size[1]),
    .o_src1_strobe (src1_strobe), .o_src1_activate (src1_act),
    .i_snk0_ready (snk0_ready), .i_snk0_size (snk_size[0]),
    .o_snk0_strobe (snk0_strobe), .o_snk0_activate (snk0_act), .o_snk0_data (snk0_data),
    .i_snk1_ready (snk1_ready), .i_snk1_size (snk_size[1]),
    .o_snk1_strobe (snk1_strobe), .o_snk1_activate (snk1_act), .o_snk1_data (snk1_data),
    .o_busy (busy), .o_finished (finished)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // FIFO models sample the DUT 1 ns after the falling edge
  always @(negedge clk) begin
    src0_data  = src_base[0] + dma_cfg_pkg::word_t'(src_idx[0]);
    src1_data  = src_base[1] + dma_cfg_pkg::word_t'(src_idx[1]);
    src0_ready = gaps ? (($random(seed) & 1) != 0) : 1'b1;
    src1_ready = gaps ? (($random(seed) & 1) != 0) : 1'b1;
    snk0_ready = gaps ? dma_cfg_pkg::pp_t'($random(seed)) : 2'b11;
    snk1_ready = gaps ? dma_cfg_pkg::pp_t'($random(seed)) : 2'b11;
    #1;
    if (src0_strobe) begin
      src_idx[0]++;
      src_cnt[0]++;
    end
    if (src1_strobe) begin
      src_idx[1]++;
      src_cnt[1]++;
    end
    if (snk0_strobe) snk0_q.push_back(snk0_data);
    if (snk1_strobe) snk1_q.push_back(snk1_data);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("watchdog timeout");
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic cmp_word(input string name, input dma_cfg_pkg::word_t exp,
                          input dma_cfg_pkg::word_t act);
    if (exp !== act)
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic cmp_count(input string name, input dma_cfg_pkg::count_t exp,
                           input dma_cfg_pkg::count_t act);
    if (exp !== act)
      fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic cmp_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic apb_write(input logic [7:0] addr, input dma_cfg_pkg::word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output dma_cfg_pkg::word_t data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    cmp_bit("apb pready", 1'b1, pready);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic dma_cfg_pkg::word_t cmd_word(input int count, input int next,
                                                  input logic chain);
    dma_cfg_pkg::word_t w;
    w = dma_cfg_pkg::word_t'(count) & 32'h00FF_FFFF;
    w[dma_reg_pkg::CMD_NEXT_HI:dma_reg_pkg::CMD_NEXT_LO] = 2'(next);
    w[dma_reg_pkg::CMD_CHAIN] = chain;
    return w;
  endfunction

  function automatic dma_cfg_pkg::word_t ctrl_word(input logic en, input int ip,
                                                   input logic sink);
    dma_cfg_pkg::word_t w;
    w = '0;
    w[dma_reg_pkg::CTRL_ENABLE] = en;
    w[dma_reg_pkg::CTRL_IP_HI:dma_reg_pkg::CTRL_IP_LO] = 2'(ip);
    w[dma_reg_pkg::CTRL_SINK] = sink;
    return w;
  endfunction

  function automatic logic [7:0] cmd_addr(input int k);
    return dma_reg_pkg::ADDR_CMD_BASE + 8'(4 * k);
  endfunction

  function automatic int round_up(input int n, input int z);
    return ((n + z - 1) / z) * z;
  endfunction

  // Sink length when the last buffer is padded and a full one reopens
  function automatic int pad_len(input int n, input int s);
    return n + s - (n % s);
  endfunction

  task automatic reset_models(input logic rand_gaps);
    gaps       = rand_gaps;
    src_idx[0] = 0;
    src_idx[1] = 0;
    src_cnt[0] = 0;
    src_cnt[1] = 0;
    snk0_q.delete();
    snk1_q.delete();
  endtask

  // want_fin selects finished rising, otherwise busy falling
  task automatic wait_status(input string what, input int ch, input logic want_fin,
                             input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      #1;
      n++;
      if (n > limit) fail_run($sformatf("%s did not happen in time", what));
    end while (want_fin ? !finished[ch] : busy[ch]);
  endtask

  // Data words first, zeros after; exp_len below zero only checks block rounding
  task automatic check_stream(input string name, input dma_cfg_pkg::word_t q[$],
                              input int start, input dma_cfg_pkg::word_t base,
                              input int n, input int s, input int exp_len);
    int len;
    len = q.size() - start;
    cmp_bit({name, " enough words"}, 1'b1, len >= n);
    for (int i = 0; i < n; i++) begin
      cmp_word(name, base + dma_cfg_pkg::word_t'(i), q[start + i]);
    end
    for (int i = n; i < len; i++) begin
      cmp_word({name, " pad"}, '0, q[start + i]);
    end
    if (exp_len >= 0) cmp_count({name, " length"}, 24'(exp_len), 24'(len));
    else cmp_bit({name, " whole blocks"}, 1'b1, (len % s) == 0);
  endtask

  task automatic test_regs();
    dma_cfg_pkg::word_t rd;
    dma_cfg_pkg::word_t w;
    logic               err;
    #1;
    cmp_bit("reset strobes", 1'b0, src0_strobe | src1_strobe | snk0_strobe | snk1_strobe);
    cmp_bit("reset activates", 1'b0, src0_act | src1_act | (|snk0_act) | (|snk1_act));
    cmp_bit("reset busy finished", 1'b0, (|busy) | (|finished));
    apb_write(dma_reg_pkg::ADDR_CTRL0, 32'h1234_56A8);
    apb_write(dma_reg_pkg::ADDR_CTRL1, 32'h0F0F_F0F6);
    apb_read(dma_reg_pkg::ADDR_CTRL0, rd, err);
    cmp_word("regs ctrl0", 32'h1234_56A8, rd);
    apb_read(dma_reg_pkg::ADDR_CTRL1, rd, err);
    cmp_word("regs ctrl1", 32'h0F0F_F0F6, rd);
    cmp_bit("regs ctrl1 pslverr", 1'b0, err);
    apb_write(dma_reg_pkg::ADDR_CTRL0, '0);
    apb_write(dma_reg_pkg::ADDR_CTRL1, '0);
    for (int k = 0; k < 4; k++) begin
      w = 32'hFA5C_3E10 ^ (32'h0111_1111 * k);
      apb_write(cmd_addr(k), w);
      apb_read(cmd_addr(k), rd, err);
      // Only the 27 command bits are stored
      cmp_word($sformatf("regs cmd%0d", k), w & 32'h07FF_FFFF, rd);
    end
    apb_read(dma_reg_pkg::ADDR_STATUS, rd, err);
    cmp_word("regs status", '0, rd);
    apb_read(8'h0C, rd, err);
    cmp_bit("regs unmapped 0x0c", 1'b1, err);
    apb_read(8'h20, rd, err);
    cmp_bit("regs unmapped 0x20", 1'b1, err);
  endtask

  task automatic test_single();
    dma_cfg_pkg::word_t rd;
    logic               err;
    reset_models(1'b0);
    src_size[0] = 8;
    snk_size[0] = 5;
    apb_write(cmd_addr(0), cmd_word(12, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b1, 0, 1'b0));
    wait_status("single finished", 0, 1'b1, 500);
    apb_read(dma_reg_pkg::ADDR_STATUS, rd, err);
    cmp_word("single status", (32'h1 << dma_reg_pkg::STS_BUSY_BASE) |
             (32'h1 << dma_reg_pkg::STS_FIN_BASE), rd);
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b0, 0, 1'b0));
    wait_status("single idle", 0, 1'b0, 500);
    check_stream("single sink0", snk0_q, 0, src_base[0], 12, 5, pad_len(12, 5));
    cmp_count("single src0 strobes", 24'(round_up(12, 8)), 24'(src_cnt[0]));
  endtask

  task automatic test_chain();
    reset_models(1'b0);
    @(negedge clk);
    src_size[1] = 6;
    snk_size[1] = 8;
    // Chain 0 to 2 to 1 with sixteen words in all
    apb_write(cmd_addr(0), cmd_word(5, 2, 1'b1));
    apb_write(cmd_addr(2), cmd_word(7, 1, 1'b1));
    apb_write(cmd_addr(1), cmd_word(4, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b1, 0, 1'b1));
    wait_status("chain finished", 1, 1'b1, 800);
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b0, 0, 1'b1));
    wait_status("chain idle", 1, 1'b0, 500);
    check_stream("chain sink1", snk1_q, 0, src_base[1], 16, 8, pad_len(16, 8));
    cmp_count("chain src1 strobes", 24'(round_up(16, 6)), 24'(src_cnt[1]));
  endtask

  task automatic test_dual();
    reset_models(1'b1);
    @(negedge clk);
    src_size[0] = 24'(3 + ($random(seed) & 7));
    src_size[1] = 24'(3 + ($random(seed) & 7));
    snk_size[0] = 24'(2 + ($random(seed) & 7));
    snk_size[1] = 24'(2 + ($random(seed) & 7));
    apb_write(cmd_addr(0), cmd_word(10, 0, 1'b0));
    apb_write(cmd_addr(3), cmd_word(13, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b1, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b1, 3, 1'b1));
    wait_status("dual ch0 finished", 0, 1'b1, 1500);
    wait_status("dual ch1 finished", 1, 1'b1, 1500);
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b0, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b0, 3, 1'b1));
    wait_status("dual ch0 idle", 0, 1'b0, 500);
    wait_status("dual ch1 idle", 1, 1'b0, 500);
    check_stream("dual sink0", snk0_q, 0, src_base[0], 10, int'(snk_size[0]), -1);
    check_stream("dual sink1", snk1_q, 0, src_base[1], 13, int'(snk_size[1]), -1);
    cmp_count("dual src0 strobes", 24'(round_up(10, int'(src_size[0]))), 24'(src_cnt[0]));
    cmp_count("dual src1 strobes", 24'(round_up(13, int'(src_size[1]))), 24'(src_cnt[1]));
  endtask

  task automatic test_contention();
    dma_cfg_pkg::word_t first [$];
    reset_models(1'b0);
    @(negedge clk);
    src_size[0] = 4;
    src_size[1] = 4;
    snk_size[0] = 3;
    apb_write(cmd_addr(0), cmd_word(6, 0, 1'b0));
    apb_write(cmd_addr(1), cmd_word(5, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b1, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b1, 1, 1'b0));
    wait_status("contention ch0 finished", 0, 1'b1, 500);
    cmp_count("contention ch1 held off", '0, 24'(src_cnt[1]));
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b0, 0, 1'b0));
    wait_status("contention ch0 idle", 0, 1'b0, 500);
    cmp_count("contention ch1 still held", '0, 24'(src_cnt[1]));
    first = snk0_q;
    check_stream("contention ch0", first, 0, src_base[0], 6, 3, pad_len(6, 3));
    wait_status("contention ch1 finished", 1, 1'b1, 500);
    apb_write(dma_reg_pkg::ADDR_CTRL1, ctrl_word(1'b0, 1, 1'b0));
    wait_status("contention ch1 idle", 1, 1'b0, 500);
    check_stream("contention ch1", snk0_q, first.size(), src_base[1], 5, 3, pad_len(5, 3));
    cmp_count("contention src1 strobes", 24'(round_up(5, 4)), 24'(src_cnt[1]));
  endtask

  task automatic test_abort();
    int k;
    int n;
    reset_models(1'b0);
    @(negedge clk);
    src_size[0] = 8;
    snk_size[0] = 6;
    apb_write(cmd_addr(0), cmd_word(40, 0, 1'b0));
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b1, 0, 1'b0));
    n = 0;
    while (snk0_q.size() < 5) begin
      @(negedge clk);
      n++;
      if (n > 500) fail_run("abort transfer never started");
    end
    apb_write(dma_reg_pkg::ADDR_CTRL0, ctrl_word(1'b0, 0, 1'b0));
    wait_status("abort idle", 0, 1'b0, 500);
    k = 0;
    while (k < snk0_q.size() && snk0_q[k] != '0) k++;
    cmp_bit("abort before count", 1'b1, k < 40);
    check_stream("abort sink0", snk0_q, 0, src_base[0], k, 6, -1);
    cmp_bit("abort src drained", 1'b1, (src_cnt[0] % 8) == 0 && src_cnt[0] >= k);
    cmp_bit("abort src released", 1'b0, src0_act);
    cmp_bit("abort snk released", 1'b0, |snk0_act);
  endtask

  initial begin
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    src0_ready  = 1'b0;
    src1_ready  = 1'b0;
    src0_data   = '0;
    src1_data   = '0;
    snk0_ready  = '0;
    snk1_ready  = '0;
    src_size[0] = 8;
    src_size[1] = 8;
    snk_size[0] = 4;
    snk_size[1] = 4;
    src_base[0] = 32'h1000_0000;
    src_base[1] = 32'h2000_0000;
    reset_models(1'b0);
    repeat (10) @(negedge clk);
    rst = 1'b0;
    test_regs();
    test_single();
    test_chain();
    test_dual();
    test_contention();
    test_abort();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/bash
# Build and run the DMA testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dma_tb \
  -f verilog.f --Mdir obj_dir -o dma_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/dma_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

// File: verilog.f
verilog/dma_cfg_pkg.sv
verilog/dma_reg_pkg.sv
verilog/dma_if.sv
verilog/dma_apb_regs.sv
verilog/dma_channel.sv
verilog/dma_src_port.sv
verilog/dma_snk_port.sv
verilog/dma_top.sv
bench/dma_assert.sv
bench/dma_tb.sv

// File: verilog/dma_apb_regs.sv
`default_nettype none
`timescale 1ns/100ps

module dma_apb_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_psel,
  input  logic                                i_penable,
  input  logic                                i_pwrite,
  input  logic [dma_reg_pkg::APB_ADDR_W-1:0]  i_paddr,
  input  dma_cfg_pkg::word_t                  i_pwdata,
  output dma_cfg_pkg::word_t                  o_prdata,
  output logic                                o_pready,
  output logic                                o_pslverr,
  output dma_cfg_pkg::word_t                  o_ctrl [dma_cfg_pkg::CHAN_COUNT],
  output dma_reg_pkg::cmd_t                   o_cmd [dma_cfg_pkg::CMD_COUNT],
  input  logic [dma_cfg_pkg::CHAN_COUNT-1:0]  i_busy,
  input  logic [dma_cfg_pkg::CHAN_COUNT-1:0]  i_finished
);

  logic                               access;
  logic                               wr_en;
  logic                               hit;
  logic                               cmd_hit;
  logic [dma_reg_pkg::APB_ADDR_W-1:0] cmd_off;
  dma_cfg_pkg::cmd_idx_t              cmd_idx;
  dma_cfg_pkg::word_t                 status;

  assign access = i_psel && i_penable;
  assign wr_en  = access && i_pwrite;

  // Command window, word aligned
  assign cmd_off = i_paddr - dma_reg_pkg::ADDR_CMD_BASE;
  assign cmd_hit = (cmd_off[dma_reg_pkg::APB_ADDR_W-1:$bits(dma_cfg_pkg::cmd_idx_t)+2] == '0) &&
                   (cmd_off[1:0] == 2'b00);
  assign cmd_idx = cmd_off[2 +: $bits(dma_cfg_pkg::cmd_idx_t)];

  always_comb begin
    status = '0;
    status[dma_reg_pkg::STS_BUSY_BASE +: dma_cfg_pkg::CHAN_COUNT] = i_busy;
    status[dma_reg_pkg::STS_FIN_BASE +: dma_cfg_pkg::CHAN_COUNT]  = i_finished;
  end

  always_comb begin
    o_prdata = '0;
    hit      = 1'b1;
    if (cmd_hit) begin
      o_prdata = dma_cfg_pkg::word_t'(o_cmd[cmd_idx]);
    end else begin
      case (i_paddr)
        dma_reg_pkg::ADDR_CTRL0:  o_prdata = o_ctrl[0];
        dma_reg_pkg::ADDR_CTRL1:  o_prdata = o_ctrl[1];
        dma_reg_pkg::ADDR_STATUS: o_prdata = status;
        default:                  hit      = 1'b0;
      endcase
    end
  end

  // No wait states
  assign o_pready  = access;
  assign o_pslverr = access && !hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < dma_cfg_pkg::CHAN_COUNT; c++) begin
        o_ctrl[c] <= '0;
      end
    end else if (wr_en) begin
      case (i_paddr)
        dma_reg_pkg::ADDR_CTRL0: o_ctrl[0] <= i_pwdata;
        dma_reg_pkg::ADDR_CTRL1: o_ctrl[1] <= i_pwdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && cmd_hit) begin
      o_cmd[cmd_idx] <= '{
        chain: i_pwdata[dma_reg_pkg::CMD_CHAIN],
        next:  i_pwdata[dma_reg_pkg::CMD_NEXT_HI:dma_reg_pkg::CMD_NEXT_LO],
        count: i_pwdata[dma_reg_pkg::CMD_COUNT_HI:0]
      };
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  localparam int CHAN_COUNT = 2;
  localparam int SINK_COUNT = 2;
  localparam int CMD_COUNT  = 4;

  // Datapath word
  typedef logic [31:0] word_t;

  // Block sizes and word counts
  typedef logic [23:0] count_t;

  typedef logic [1:0]  cmd_idx_t;
  typedef logic [0:0]  sink_idx_t;

  // One flag per ping-pong buffer
  typedef logic [1:0]  pp_t;

  typedef enum logic [2:0] {
    CH_IDLE,
    CH_SETUP,
    CH_ACTIVE,
    CH_FLUSH,
    CH_FINISHED
  } chan_state_t;

endpackage

`default_nettype wire

// File: verilog/dma_channel.sv
`default_nettype none
`timescale 1ns/100ps

module dma_channel (
  input  logic               clk,
  input  logic               rst,
  input  dma_cfg_pkg::word_t i_ctrl,
  input  dma_reg_pkg::cmd_t  i_cmd [dma_cfg_pkg::CMD_COUNT],
  dma_src_if.chan            src,
  dma_xfer_if.chan           xfer,
  output logic               o_busy,
  output logic               o_finished
);

  dma_cfg_pkg::chan_state_t state;
  dma_cfg_pkg::cmd_idx_t    ip;
  dma_cfg_pkg::sink_idx_t   sel;
  dma_cfg_pkg::count_t      cnt;
  logic                     enable;
  logic                     move;

  assign enable = i_ctrl[dma_reg_pkg::CTRL_ENABLE];

  // Word moves only when source and granted sink are both ready
  assign move = (state == dma_cfg_pkg::CH_ACTIVE) && enable && (cnt != '0) &&
                src.valid && xfer.grant[sel] && xfer.ready[sel];

  assign src.run   = (state == dma_cfg_pkg::CH_ACTIVE);
  assign src.drain = (state == dma_cfg_pkg::CH_FLUSH);
  assign src.take  = move;

  // Dropping claim in flush tells the sink to pad its open buffer
  assign xfer.claim = (state == dma_cfg_pkg::CH_SETUP) ||
                      (state == dma_cfg_pkg::CH_ACTIVE) ||
                      (state == dma_cfg_pkg::CH_FINISHED);
  assign xfer.sel   = sel;
  assign xfer.push  = move;
  assign xfer.data  = src.data;

  assign o_busy     = (state != dma_cfg_pkg::CH_IDLE);
  assign o_finished = (state == dma_cfg_pkg::CH_FINISHED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_cfg_pkg::CH_IDLE;
      ip    <= '0;
      sel   <= '0;
      cnt   <= '0;
    end else begin
      case (state)
        dma_cfg_pkg::CH_IDLE: begin
          if (enable) begin
            state <= dma_cfg_pkg::CH_SETUP;
            ip    <= i_ctrl[dma_reg_pkg::CTRL_IP_HI:dma_reg_pkg::CTRL_IP_LO];
            sel   <= i_ctrl[dma_reg_pkg::CTRL_SINK];
          end
        end
        dma_cfg_pkg::CH_SETUP: begin
          cnt   <= i_cmd[ip].count;
          state <= dma_cfg_pkg::CH_ACTIVE;
        end
        dma_cfg_pkg::CH_ACTIVE: begin
          if (!enable) begin
            state <= dma_cfg_pkg::CH_FLUSH;
          end else if (cnt == '0) begin
            // Command exhausted, follow the chain or stop
            if (i_cmd[ip].chain) begin
              ip  <= i_cmd[ip].next;
              cnt <= i_cmd[i_cmd[ip].next].count;
            end else begin
              state <= dma_cfg_pkg::CH_FINISHED;
            end
          end else if (move) begin
            cnt <= cnt - 1'b1;
          end
        end
        dma_cfg_pkg::CH_FINISHED: begin
          if (!enable) begin
            state <= dma_cfg_pkg::CH_FLUSH;
          end
        end
        dma_cfg_pkg::CH_FLUSH: begin
          // Wait for source drain and sink padding
          if (src.done && xfer.done[sel]) begin
            state <= dma_cfg_pkg::CH_IDLE;
          end
        end
        default: state <= dma_cfg_pkg::CH_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_if.sv
`default_nettype none
`timescale 1ns/100ps

// Channel to source port
interface dma_src_if;
  logic               run;
  logic               drain;
  logic               take;
  logic               valid;
  logic               done;
  dma_cfg_pkg::word_t data;

  modport chan (output run, output drain, output take,
                input valid, input done, input data);
  modport port (input run, input drain, input take,
                output valid, output done, output data);
endinterface

// Channel to sink ports
interface dma_xfer_if;
  logic                   claim;
  dma_cfg_pkg::sink_idx_t sel;
  logic                   push;
  dma_cfg_pkg::word_t     data;
  // One bit per sink, each sink port drives its own bit
  logic [dma_cfg_pkg::SINK_COUNT-1:0] grant;
  logic [dma_cfg_pkg::SINK_COUNT-1:0] ready;
  logic [dma_cfg_pkg::SINK_COUNT-1:0] done;

  modport chan (output claim, output sel, output push, output data,
                input grant, input ready, input done);
  modport snk  (input claim, input sel, input push, input data,
                output grant, output ready, output done);
endinterface

`default_nettype wire

// File: verilog/dma_reg_pkg.sv
`default_nettype none

package dma_reg_pkg;

  localparam int APB_ADDR_W = 8;

  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL0    = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL1    = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS   = 8'h08;
  // Entry k at base + 4k
  localparam logic [APB_ADDR_W-1:0] ADDR_CMD_BASE = 8'h10;

  // Channel control word
  localparam int CTRL_ENABLE = 0;
  localparam int CTRL_IP_LO  = 1;
  localparam int CTRL_IP_HI  = 2;
  localparam int CTRL_SINK   = 3;

  // Command entry word
  localparam int CMD_COUNT_HI = 23;
  localparam int CMD_NEXT_LO  = 24;
  localparam int CMD_NEXT_HI  = 25;
  localparam int CMD_CHAIN    = 26;

  // Status word, one bit per channel in each field
  localparam int STS_BUSY_BASE = 0;
  localparam int STS_FIN_BASE  = 2;

  typedef struct packed {
    logic                  chain;
    dma_cfg_pkg::cmd_idx_t next;
    dma_cfg_pkg::count_t   count;
  } cmd_t;

endpackage

`default_nettype wire

// File: verilog/dma_snk_port.sv
`default_nettype none
`timescale 1ns/100ps

module dma_snk_port #(
  parameter int SINK_ID = 0
) (
  input  logic                clk,
  input  logic                rst,
  dma_xfer_if.snk             xfer [dma_cfg_pkg::CHAN_COUNT],
  input  dma_cfg_pkg::pp_t    i_snk_ready,
  input  dma_cfg_pkg::count_t i_snk_size,
  output logic                o_snk_strobe,
  output dma_cfg_pkg::pp_t    o_snk_activate,
  output dma_cfg_pkg::word_t  o_snk_data
);

  logic [dma_cfg_pkg::CHAN_COUNT-1:0] claim_v;
  logic [dma_cfg_pkg::CHAN_COUNT-1:0] push_v;
  // One-hot owner, zero when the sink is free
  logic [dma_cfg_pkg::CHAN_COUNT-1:0] own_oh;
  dma_cfg_pkg::word_t                 data_v [dma_cfg_pkg::CHAN_COUNT];
  dma_cfg_pkg::word_t                 mux_data;
  dma_cfg_pkg::count_t                cnt;
  logic                               own_claim;
  logic                               buf_open;
  logic                               room;
  logic                               padding;
  logic                               push;

  for (genvar c = 0; c < dma_cfg_pkg::CHAN_COUNT; c++) begin : g_chan
    assign claim_v[c] = xfer[c].claim && (xfer[c].sel == dma_cfg_pkg::sink_idx_t'(SINK_ID));
    assign push_v[c]  = xfer[c].push;
    assign data_v[c]  = xfer[c].data;

    assign xfer[c].grant[SINK_ID] = own_oh[c] && claim_v[c];
    assign xfer[c].ready[SINK_ID] = room && own_claim;
    assign xfer[c].done[SINK_ID]  = !(own_oh[c] && buf_open);
  end

  always_comb begin
    mux_data = '0;
    for (int c = 0; c < dma_cfg_pkg::CHAN_COUNT; c++) begin
      if (own_oh[c]) begin
        mux_data = data_v[c];
      end
    end
  end

  assign own_claim = |(own_oh & claim_v);
  assign buf_open  = (o_snk_activate != '0);
  assign room      = buf_open && (cnt < i_snk_size);
  // Owner gone with a buffer still open
  assign padding   = (own_oh != '0) && !own_claim && buf_open;
  assign push      = |(own_oh & claim_v & push_v);

  assign o_snk_strobe = push || (padding && room);
  assign o_snk_data   = padding ? '0 : mux_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      own_oh         <= '0;
      o_snk_activate <= '0;
      cnt            <= '0;
    end else begin
      // Lowest claiming channel wins a free sink
      if (own_oh == '0) begin
        own_oh <= claim_v & (~claim_v + 1'b1);
      end else if (!own_claim && !buf_open) begin
        own_oh <= '0;
      end

      if (!buf_open) begin
        if (own_claim && (i_snk_ready != '0)) begin
          o_snk_activate <= i_snk_ready & (~i_snk_ready + 1'b1);
          cnt            <= '0;
        end
      end else if (!room) begin
        o_snk_activate <= '0;
      end else if (o_snk_strobe) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_src_port.sv
`default_nettype none
`timescale 1ns/100ps

module dma_src_port (
  input  logic                clk,
  input  logic                rst,
  dma_src_if.port             src,
  input  logic                i_src_ready,
  input  dma_cfg_pkg::word_t  i_src_data,
  input  dma_cfg_pkg::count_t i_src_size,
  output logic                o_src_strobe,
  output logic                o_src_activate
);

  logic                act;
  logic                below;
  dma_cfg_pkg::count_t cnt;

  assign below = (cnt < i_src_size);

  assign src.valid = act && below;
  assign src.data  = i_src_data;
  assign src.done  = !act;

  // Drain strobes out the rest of the open block on its own
  assign o_src_strobe   = src.take || (src.drain && act && below);
  assign o_src_activate = act;

  always_ff @(posedge clk) begin
    if (rst) begin
      act <= 1'b0;
      cnt <= '0;
    end else if (!act) begin
      if (src.run && i_src_ready) begin
        act <= 1'b1;
        cnt <= '0;
      end
    end else if (!below) begin
      // Block used up
      act <= 1'b0;
    end else if (o_src_strobe) begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_top.sv
`default_nettype none
`timescale 1ns/100ps

module dma_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  logic [dma_reg_pkg::APB_ADDR_W-1:0] i_paddr,
  input  dma_cfg_pkg::word_t                 i_pwdata,
  output dma_cfg_pkg::word_t                 o_prdata,
  output logic                               o_pready,
  output logic                               o_pslverr,
  input  logic                               i_src0_ready,
  input  dma_cfg_pkg::word_t                 i_src0_data,
  input  dma_cfg_pkg::count_t                i_src0_size,
  output logic                               o_src0_strobe,
  output logic                               o_src0_activate,
  input  logic                               i_src1_ready,
  input  dma_cfg_pkg::word_t                 i_src1_data,
  input  dma_cfg_pkg::count_t                i_src1_size,
  output logic                               o_src1_strobe,
  output logic                               o_src1_activate,
  input  dma_cfg_pkg::pp_t                   i_snk0_ready,
  input  dma_cfg_pkg::count_t                i_snk0_size,
  output logic                               o_snk0_strobe,
  output dma_cfg_pkg::pp_t                   o_snk0_activate,
  output dma_cfg_pkg::word_t                 o_snk0_data,
  input  dma_cfg_pkg::pp_t                   i_snk1_ready,
  input  dma_cfg_pkg::count_t                i_snk1_size,
  output logic                               o_snk1_strobe,
  output dma_cfg_pkg::pp_t                   o_snk1_activate,
  output dma_cfg_pkg::word_t                 o_snk1_data,
  output logic [dma_cfg_pkg::CHAN_COUNT-1:0] o_busy,
  output logic [dma_cfg_pkg::CHAN_COUNT-1:0] o_finished
);

  dma_cfg_pkg::word_t ctrl [dma_cfg_pkg::CHAN_COUNT];
  dma_reg_pkg::cmd_t  cmd  [dma_cfg_pkg::CMD_COUNT];

  dma_src_if  src_if  [dma_cfg_pkg::CHAN_COUNT] ();
  dma_xfer_if xfer_if [dma_cfg_pkg::CHAN_COUNT] ();

  dma_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .o_ctrl     (ctrl),
    .o_cmd      (cmd),
    .i_busy     (o_busy),
    .i_finished (o_finished)
  );

  for (genvar c = 0; c < dma_cfg_pkg::CHAN_COUNT; c++) begin : g_chan
    dma_channel u_chan (
      .clk        (clk),
      .rst        (rst),
      .i_ctrl     (ctrl[c]),
      .i_cmd      (cmd),
      .src        (src_if[c]),
      .xfer       (xfer_if[c]),
      .o_busy     (o_busy[c]),
      .o_finished (o_finished[c])
    );
  end

  dma_src_port u_src0 (
    .clk            (clk),
    .rst            (rst),
    .src            (src_if[0]),
    .i_src_ready    (i_src0_ready),
    .i_src_data     (i_src0_data),
    .i_src_size     (i_src0_size),
    .o_src_strobe   (o_src0_strobe),
    .o_src_activate (o_src0_activate)
  );

  dma_src_port u_src1 (
    .clk            (clk),
    .rst            (rst),
    .src            (src_if[1]),
    .i_src_ready    (i_src1_ready),
    .i_src_data     (i_src1_data),
    .i_src_size     (i_src1_size),
    .o_src_strobe   (o_src1_strobe),
    .o_src_activate (o_src1_activate)
  );

  dma_snk_port #(.SINK_ID(0)) u_snk0 (
    .clk            (clk),
    .rst            (rst),
    .xfer           (xfer_if),
    .i_snk_ready    (i_snk0_ready),
    .i_snk_size     (i_snk0_size),
    .o_snk_strobe   (o_snk0_strobe),
    .o_snk_activate (o_snk0_activate),
    .o_snk_data     (o_snk0_data)
  );

  dma_snk_port #(.SINK_ID(1)) u_snk1 (
    .clk            (clk),
    .rst            (rst),
    .xfer           (xfer_if),
    .i_snk_ready    (i_snk1_ready),
    .i_snk_size     (i_snk1_size),
    .o_snk_strobe   (o_snk1_strobe),
    .o_snk_activate (o_snk1_activate),
    .o_snk_data     (o_snk1_data)
  );

endmodule

`default_nettype wire
